// File: logic/perf_settings.svh
`ifndef PERF_SETTINGS_SVH
`define PERF_SETTINGS_SVH

// Width of every performance counter, all of them wrap at this size
`define PERF_COUNT_WIDTH 32

// Read port address width, enough for six counters plus two spare
`define PERF_ADDR_WIDTH 3

// Read port address map
`define PERF_ADDR_BRANCH_TOTAL 3'd0
`define PERF_ADDR_BRANCH_MISS  3'd1
`define PERF_ADDR_CACHE_HIT    3'd2
`define PERF_ADDR_CACHE_MISS   3'd3
`define PERF_ADDR_CACHE_ACCESS 3'd4
`define PERF_ADDR_CACHE_TIMER  3'd5

// Addresses 6 and 7 are unused and read back as zero

`endif

// File: logic/perfEventPkg.sv
package perfEventPkg;

    // Strobes from the core, one cycle each
    typedef struct packed {
        logic executed;    // A branch retired this cycle
        logic mispredict;  // Only meaningful with executed
    } branchEventT;

    // Strobes from the cache, one cycle each
    //   hit and miss never fire together
    //   start opens an access window and is one access
    //   finish closes the open window
    typedef struct packed {
        logic hit;
        logic miss;
        logic start;
        logic finish;
    } cacheEventT;

endpackage

// File: logic/perfCountPkg.sv
`include "perf_settings.svh"

package perfCountPkg;

    // Raw counter value
    typedef logic [`PERF_COUNT_WIDTH-1:0] countT;

    // Read port address
    typedef logic [`PERF_ADDR_WIDTH-1:0] regAddrT;

    // Branch counter group
    typedef struct packed {
        countT total;         // Branches executed
        countT mispredicted;  // Executed and mispredicted
    } branchCountsT;

    // Cache counter group
    typedef struct packed {
        countT hit;
        countT miss;
        countT access;  // One per window start
        countT timer;   // Cycles spent in open windows
    } cacheCountsT;

    // Access window tracker
    typedef enum logic {
        idle     = 1'b0,
        counting = 1'b1
    } timerStateT;

endpackage

// File: logic/branchCounter.sv
`timescale 1ns/1ps

module branchCounter
    import perfEventPkg::*;
    import perfCountPkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         clear,         // Zero both counters
    input  branchEventT  branchEvent,
    output branchCountsT branchCounts
);

    logic countMiss;  // Mispredict qualified by executed

    assign countMiss = branchEvent.executed & branchEvent.mispredict;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            branchCounts <= '0;
        end else if (clear) begin
            branchCounts <= '0;  // Events in this cycle are dropped
        end else begin
            if (branchEvent.executed) begin
                branchCounts.total <= branchCounts.total + countT'(1);
            end
            if (countMiss) begin
                branchCounts.mispredicted <= branchCounts.mispredicted + countT'(1);
            end
        end
    end

    // A lone mispredict strobe points at a faulty core, the counter ignores it
    mispredictNeedsExecuted: assert property (
        @(posedge clk) disable iff (rst)
        branchEvent.mispredict |-> branchEvent.executed
    ) else $error("branchCounter: mispredict without executed");

endmodule

// File: logic/cacheCounter.sv
`timescale 1ns/1ps

module cacheCounter
    import perfEventPkg::*;
    import perfCountPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        clear,        // Zero counters, close window
    input  cacheEventT  cacheEvent,
    output cacheCountsT cacheCounts
);

    timerStateT state;
    timerStateT nextState;

    // Window tracking, finish wins when it meets start
    always_comb begin
        nextState = state;
        if (cacheEvent.finish) begin
            nextState = idle;
        end else if (cacheEvent.start) begin
            nextState = counting;  // Also holds an already open window
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= idle;
        end else if (clear) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cacheCounts <= '0;
        end else if (clear) begin
            cacheCounts <= '0;  // Same-cycle events discarded
        end else begin
            if (cacheEvent.hit) begin
                cacheCounts.hit <= cacheCounts.hit + countT'(1);
            end
            if (cacheEvent.miss) begin
                cacheCounts.miss <= cacheCounts.miss + countT'(1);
            end
            if (cacheEvent.start) begin
                cacheCounts.access <= cacheCounts.access + countT'(1);
            end
            // One tick per edge spent inside a window
            if (state == counting) begin
                cacheCounts.timer <= cacheCounts.timer + countT'(1);
            end
        end
    end

    hitMissExclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(cacheEvent.hit && cacheEvent.miss)
    ) else $error("cacheCounter: hit and miss in the same cycle");

    // Closing a window that was never opened
    finishNeedsWindow: assert property (
        @(posedge clk) disable iff (rst)
        (state == idle && !cacheEvent.start) |-> !cacheEvent.finish
    ) else $error("cacheCounter: finish with no open access window");

endmodule

// File: logic/perfReadout.sv
`timescale 1ns/1ps
`include "perf_settings.svh"

module perfReadout
    import perfCountPkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  branchCountsT branchCounts,
    input  cacheCountsT  cacheCounts,
    input  logic         readEn,      // Read request strobe
    input  regAddrT      readAddr,
    output logic         readValid,   // One cycle after readEn
    output countT        readData
);

    countT selected;  // Counter at readAddr before this cycle's events

    always_comb begin
        case (readAddr)
            `PERF_ADDR_BRANCH_TOTAL: begin
                selected = branchCounts.total;
            end
            `PERF_ADDR_BRANCH_MISS: begin
                selected = branchCounts.mispredicted;
            end
            `PERF_ADDR_CACHE_HIT: begin
                selected = cacheCounts.hit;
            end
            `PERF_ADDR_CACHE_MISS: begin
                selected = cacheCounts.miss;
            end
            `PERF_ADDR_CACHE_ACCESS: begin
                selected = cacheCounts.access;
            end
            `PERF_ADDR_CACHE_TIMER: begin
                selected = cacheCounts.timer;
            end
            default: begin
                selected = '0;  // Spare addresses
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            readValid <= 1'b0;
        end else begin
            readValid <= readEn;
        end
    end

    // Data only moves on a request, so it holds between reads
    always_ff @(posedge clk) begin
        if (readEn) begin
            readData <= selected;
        end
    end

endmodule

// File: logic/perfMonitor.sv
`timescale 1ns/1ps

module perfMonitor
    import perfEventPkg::*;
    import perfCountPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        clear,        // Zero every counter
    input  branchEventT branchEvent,  // From the core
    input  cacheEventT  cacheEvent,   // From the cache
    input  logic        readEn,
    input  regAddrT     readAddr,
    output logic        readValid,
    output countT       readData
);

    branchCountsT branchCounts;
    cacheCountsT  cacheCounts;

    // Branch events
    branchCounter branchCounterInst (
        .clk          (clk),
        .rst          (rst),
        .clear        (clear),
        .branchEvent  (branchEvent),
        .branchCounts (branchCounts)
    );

    // Cache events and access window timer
    cacheCounter cacheCounterInst (
        .clk         (clk),
        .rst         (rst),
        .clear       (clear),
        .cacheEvent  (cacheEvent),
        .cacheCounts (cacheCounts)
    );

    // Single read port over all six counters
    perfReadout perfReadoutInst (
        .clk          (clk),
        .rst          (rst),
        .branchCounts (branchCounts),
        .cacheCounts  (cacheCounts),
        .readEn       (readEn),
        .readAddr     (readAddr),
        .readValid    (readValid),
        .readData     (readData)
    );

endmodule

// File: bench/perfMonitorTb.sv
`timescale 1ns/1ps
`include "perf_settings.svh"

module perfMonitorTb
    import perfEventPkg::*;
    import perfCountPkg::*;
();

    localparam int validTimeout = 20;  // Cycles allowed for readValid

    // Model of every counter plus the window state
    typedef struct packed {
        branchCountsT branch;
        cacheCountsT  cache;
        timerStateT   state;
    } modelT;

    logic        clk;
    logic        rst;
    logic        clear;
    branchEventT branchEvent;
    cacheEventT  cacheEvent;
    logic        readEn;
    regAddrT     readAddr;
    logic        readValid;
    countT       readData;

    modelT model;
    countT expQ[$];       // Expected read results, oldest first
    bit    tbWindow;      // Mirrors the DUT window state
    bit    timedOut;
    int    errorCount;
    int    readsChecked;

    perfMonitor DUT (
        .clk         (clk),
        .rst         (rst),
        .clear       (clear),
        .branchEvent (branchEvent),
        .cacheEvent  (cacheEvent),
        .readEn      (readEn),
        .readAddr    (readAddr),
        .readValid   (readValid),
        .readData    (readData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Next counter values after one clock edge
    function automatic modelT nextModel(input modelT m, input logic clr,
                                        input branchEventT b, input cacheEventT c);
        modelT n;
        n = m;
        if (clr) begin
            n = '0;  // Window closes, events dropped
            n.state = idle;
        end else begin
            if (b.executed) n.branch.total = m.branch.total + 1;
            if (b.executed && b.mispredict) n.branch.mispredicted = m.branch.mispredicted + 1;
            if (c.hit) n.cache.hit = m.cache.hit + 1;
            if (c.miss) n.cache.miss = m.cache.miss + 1;
            if (c.start) n.cache.access = m.cache.access + 1;
            if (m.state == counting) n.cache.timer = m.cache.timer + 1;
            if (c.finish) begin
                n.state = idle;  // Finish beats start
            end else if (c.start) begin
                n.state = counting;
            end
        end
        return n;
    endfunction

    function automatic countT readModel(input modelT m, input regAddrT a);
        case (a)
            `PERF_ADDR_BRANCH_TOTAL: return m.branch.total;
            `PERF_ADDR_BRANCH_MISS:  return m.branch.mispredicted;
            `PERF_ADDR_CACHE_HIT:    return m.cache.hit;
            `PERF_ADDR_CACHE_MISS:   return m.cache.miss;
            `PERF_ADDR_CACHE_ACCESS: return m.cache.access;
            `PERF_ADDR_CACHE_TIMER:  return m.cache.timer;
            default:                 return '0;
        endcase
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            model = '0;
        end else begin
            if (readEn) expQ.push_back(readModel(model, readAddr));  // Value before this edge
            model = nextModel(model, clear, branchEvent, cacheEvent);
        end
    end

    task automatic checkValue(input string name, input countT actual, input countT expected);
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic waitForValid(output bit seen);
        int waited;
        waited = 0;
        while (!readValid && waited < validTimeout) begin
            @(negedge clk);
            waited++;
        end
        seen = readValid;
    endtask

    initial begin : compareReads
        bit    gotValid;
        countT expected;
        forever begin
            @(negedge clk);
            if (!timedOut && expQ.size() != 0) begin
                waitForValid(gotValid);
                if (gotValid) begin
                    expected = expQ.pop_front();
                    checkValue("readData", readData, expected);
                    readsChecked++;
                end else begin
                    $display("Timeout: readValid never came after a read request");
                    errorCount++;
                    timedOut = 1'b1;
                end
            end else if (!timedOut && !rst && readValid) begin
                $display("Error at %0t ns: readValid rose with no read pending", $time);
                errorCount++;
            end
        end
    end

    function automatic branchEventT randBranch();
        branchEventT b;
        b.executed   = $urandom_range(0, 1);
        b.mispredict = b.executed && ($urandom_range(0, 3) == 0);  // Only with executed
        return b;
    endfunction

    function automatic cacheEventT randCache();
        cacheEventT  c;
        int unsigned pick;
        pick    = $urandom_range(0, 3);
        c       = '0;
        c.hit   = (pick == 1);
        c.miss  = (pick == 2);
        c.start = ($urandom_range(0, 5) == 0);
        if (tbWindow || c.start) c.finish = ($urandom_range(0, 4) == 0);
        return c;
    endfunction

    task automatic driveCycle(input branchEventT b, input cacheEventT c, input bit rdOn,
                              input regAddrT addr, input bit clr);
        @(negedge clk);
        branchEvent = b;
        cacheEvent  = c;
        readEn      = rdOn;
        readAddr    = addr;
        clear       = clr;
        if (clr || c.finish) begin
            tbWindow = 1'b0;
        end else if (c.start) begin
            tbWindow = 1'b1;
        end
    endtask

    task automatic readAll();
        for (int a = 0; a < 8; a++) driveCycle('0, '0, 1'b1, regAddrT'(a), 1'b0);
        driveCycle('0, '0, 1'b0, '0, 1'b0);
    endtask

    task automatic closeWindow();
        cacheEventT c;
        c = '0;
        c.finish = 1'b1;
        if (tbWindow) driveCycle('0, c, 1'b0, '0, 1'b0);
    endtask

    // Start at S, finish at S plus len
    task automatic runWindow(input int len, input int gap);
        cacheEventT c;
        c        = '0;
        c.start  = 1'b1;
        c.finish = (len == 0);
        driveCycle(randBranch(), c, 1'b0, '0, 1'b0);
        if (len > 0) begin
            repeat (len - 1) driveCycle(randBranch(), '0, 1'b0, '0, 1'b0);
            c        = '0;
            c.finish = 1'b1;
            driveCycle(randBranch(), c, $urandom_range(0, 3) == 0, `PERF_ADDR_CACHE_TIMER, 1'b0);
        end
        repeat (gap) driveCycle(randBranch(), '0, 1'b0, '0, 1'b0);
    endtask

    initial begin : mainFlow
        int waited;
        void'($urandom(90949));
        rst         = 1'b1;
        clear       = 1'b0;
        branchEvent = '0;
        cacheEvent  = '0;
        readEn      = 1'b0;
        readAddr    = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // Quiet after reset, then every address reads zero
        repeat (5) begin
            driveCycle('0, '0, 1'b0, '0, 1'b0);
            checkValue("readValid", countT'(readValid), '0);
        end
        readAll();

        repeat (500) begin
            driveCycle(randBranch(), '0, $urandom_range(0, 7) == 0,
                       regAddrT'($urandom_range(0, 1)), 1'b0);
        end
        readAll();

        repeat (400) begin
            driveCycle('0, randCache(), $urandom_range(0, 7) == 0,
                       regAddrT'($urandom_range(2, 4)), 1'b0);
        end
        closeWindow();
        readAll();

        // Window lengths 0 to 6, gap 0 gives back-to-back windows
        repeat (40) runWindow($urandom_range(0, 6), $urandom_range(0, 2));
        readAll();

        repeat (50) driveCycle(randBranch(), randCache(), 1'b0, '0, 1'b0);
        driveCycle(randBranch(), randCache(), 1'b1, regAddrT'($urandom_range(0, 7)), 1'b1);
        readAll();
        repeat (100) begin
            driveCycle(randBranch(), randCache(), $urandom_range(0, 3) == 0,
                       regAddrT'($urandom_range(0, 7)), 1'b0);
        end
        readAll();

        // One read per cycle across the whole map
        for (int i = 0; i < 240; i++) begin
            driveCycle(randBranch(), randCache(), 1'b1, regAddrT'(i % 8), 1'b0);
        end
        driveCycle('0, '0, 1'b0, '0, 1'b0);
        readAll();

        waited = 0;
        while (expQ.size() != 0 && !timedOut && waited < validTimeout) begin
            @(negedge clk);
            waited++;
        end
        if (expQ.size() != 0 && !timedOut) begin
            $display("Timeout: %0d read results never arrived", expQ.size());
            errorCount++;
        end

        $display("Reads checked: %0d, errors: %0d", readsChecked, errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+logic
logic/perfEventPkg.sv
logic/perfCountPkg.sv
logic/branchCounter.sv
logic/cacheCounter.sv
logic/perfReadout.sv
logic/perfMonitor.sv
bench/perfMonitorTb.sv
